/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = glueTb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/glueChecker.sv */
`timescale 1ns/10ps

`include "glue_consts.svh"

module glueChecker (
    input  logic clk40, rst, tsN, rnw, ovl,
    input  logic [1:0] romDelay,
    input  logic [31:1] addr,
    input  logic [3:0] dataIn,
    input  logic tackN, dataOe, configEnN, romEnN, flashEnN, flashReadN, flashWriteN,
    input  logic rtcEnN, bridgeEnN, ataEnN,
    input  logic [3:0] dataOut,
    output int errCount
);

    import glue_pkg::*;

    localparam logic [63:0] bridgeTable = `BRIDGE_ID;
    localparam logic [63:0] ataTable    = `ATA_ID;

    logic       tracking, last, act;
    int         k;
    busSpace    curSpace;
    logic [3:0] curWait, lo;
    logic [7:0] bb, ab;
    logic [1:0] board;
    logic [6:0] expCycle;

    initial errCount = 0;

    // Expected {space, wait count} of a cycle
    function automatic logic [6:0] refCycle(input logic [31:16] a, input logic ov,
        input logic [7:0] bBase, input logic [7:0] aBase, input logic [1:0] brd,
        input logic [1:0] delay);
        logic [7:0] p;
        p = a[23:16];
        if (a[31:24] != 8'h00) return {spaceNone, 4'd0};
        if (p >= `ROM_PAGE || (ov && p == 8'h00)) return {spaceRom, `ROM_WAIT + {2'b00, delay}};
        if (p >= `FLASH_PAGE) return {spaceFlash, `FLASH_WAIT};
        if (p == `RTC_PAGE) return {spaceRtc, `RTC_WAIT};
        if (p == `AC_PAGE && brd != 2'd2) return {spaceAutoconfig, `AC_WAIT};
        if (bBase != 8'h00 && p == bBase) return {spaceBridge, `BOARD_WAIT};
        if (aBase != 8'h00 && p == aBase) return {spaceAta, `BOARD_WAIT};
        return {spaceNone, 4'd0};
    endfunction

    // Identity nibble as seen on the bus
    function automatic logic [3:0] refNibble(input logic [1:0] brd, input logic [6:0] off);
        logic [3:0] n;
        n = 4'h0;
        if (off < 7'd16) n = (brd == 2'd0) ? bridgeTable[off*4 +: 4] : ataTable[off*4 +: 4];
        return (off < 7'd2) ? n : ~n;
    endfunction

    task automatic checkBit(input string name, input logic [3:0] exp, input logic [3:0] got);
        if (exp !== got) begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            errCount++;
        end
    endtask

    always @(posedge clk40) begin
        if (rst) begin
            tracking = 1'b0;
            k = 0;
            bb = 8'h00;
            ab = 8'h00;
            lo = 4'h0;
            board = 2'd0;
        end else begin
            act  = tracking;
            last = tracking && (k + 1 == int'(curWait) + 2);
            if (!tackN && !last) begin
                $display("Unexpected acknowledge at time %0t", $time);
                errCount++;
            end else if (tackN && last) begin
                $display("Missing acknowledge at time %0t", $time);
                errCount++;
            end
            // Config writes land on the acknowledge edge
            if (last && curSpace == spaceAutoconfig && !rnw) begin
                if (addr[7:1] == `AC_BASE_LO) lo = dataIn;
                if (addr[7:1] == `AC_BASE_HI && board == 2'd0) bb = {dataIn, lo};
                if (addr[7:1] == `AC_BASE_HI && board == 2'd1) ab = {dataIn, lo};
                if (addr[7:1] == `AC_BASE_HI || addr[7:1] == `AC_SHUTUP) board = board + 2'd1;
            end
            checkBit("romEnN", {3'd0, !(act && curSpace == spaceRom)}, {3'd0, romEnN});
            checkBit("flashEnN", {3'd0, !(act && curSpace == spaceFlash)}, {3'd0, flashEnN});
            checkBit("rtcEnN", {3'd0, !(act && curSpace == spaceRtc)}, {3'd0, rtcEnN});
            checkBit("bridgeEnN", {3'd0, !(act && curSpace == spaceBridge)}, {3'd0, bridgeEnN});
            checkBit("ataEnN", {3'd0, !(act && curSpace == spaceAta)}, {3'd0, ataEnN});
            checkBit("flashReadN", {3'd0, !(act && curSpace == spaceFlash && rnw)},
                {3'd0, flashReadN});
            checkBit("flashWriteN", {3'd0, !(act && curSpace == spaceFlash && !rnw)},
                {3'd0, flashWriteN});
            checkBit("dataOe", {3'd0, act && curSpace == spaceAutoconfig && rnw}, {3'd0, dataOe});
            checkBit("configEnN", {3'd0, board != 2'd2}, {3'd0, configEnN});
            if (last && curSpace == spaceAutoconfig && rnw) begin
                checkBit("dataOut", refNibble(board, addr[7:1]), dataOut);
            end
            if (tracking) k = k + 1;
            if (last) begin
                tracking = 1'b0;
            end else if (!tsN && !act) begin
                expCycle = refCycle(addr[31:16], ovl, bb, ab, board, romDelay);
                curSpace = busSpace'(expCycle[6:4]);
                curWait  = expCycle[3:0];
                tracking = (curSpace != spaceNone);
                k = 0;
            end
        end
    end

endmodule

/* bench/glueTb.sv */
`timescale 1ns/10ps

`include "glue_consts.svh"

module glueTb;

    // Bus cycles in the run, two resets of 16 cycles
    localparam int numCycles  = 152;
    localparam int cycleLimit = numCycles * 16 + 2 * 16;

    logic clk40 = 1'b0, rst, tsN, rnw, ovl, configInN;
    logic [1:0] romDelay;
    logic [31:1] addr;
    logic [3:0] dataIn, dataOut;
    logic tackN, dataOe, configEnN, romEnN, flashEnN, flashReadN, flashWriteN;
    logic rtcEnN, bridgeEnN, ataEnN;
    int checkErrors, benchErrors = 0, cycleCount = 0;
    logic [31:0] lfsrState = 32'd73267;
    logic [31:0] r;

    glueTop dut (.*);

    glueChecker uCheck (.clk40, .rst, .tsN, .rnw, .ovl, .romDelay, .addr, .dataIn,
        .tackN, .dataOe, .configEnN, .romEnN, .flashEnN, .flashReadN, .flashWriteN, .rtcEnN,
        .bridgeEnN, .ataEnN, .dataOut, .errCount(checkErrors));

    always #50 clk40 = !clk40;

    always @(posedge clk40) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Run stopped after %0d cycles without finishing", cycleCount);
            $display("Finished with errors");
            $finish;
        end
    end

    ///////////////////////////////
    // Stimulus helpers
    ///////////////////////////////

    // Galois LFSR, one step per bit
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'hA300_0000 : lfsrState >> 1;
        end
        return v;
    endfunction

    task automatic applyReset();
        @(negedge clk40);
        rst = 1'b1;
        repeat (16) @(negedge clk40);
        rst = 1'b0;
    endtask

    // One bus cycle, waits for tackN up to 12 clocks
    task automatic busCycle(input logic [31:0] a, input logic r, input logic [3:0] d,
        input logic expectAck);
        int waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        @(negedge clk40);
        addr = a[31:1];
        rnw = r;
        dataIn = d;
        tsN = 1'b0;
        @(negedge clk40);
        tsN = 1'b1;
        while (!seen && waited < 12) begin
            if (!tackN) seen = 1'b1;
            else begin
                @(negedge clk40);
                waited++;
            end
        end
        if (seen != expectAck) begin
            $display("Acknowledge %s for address %h", seen ? "appeared" : "missing", a);
            benchErrors++;
        end
    endtask

    function automatic logic [31:0] acAddr(input logic [6:0] off);
        return {8'h00, `AC_PAGE, 8'h00, off, 1'b0};
    endfunction

    ///////////////////////////////
    // Test sequence
    ///////////////////////////////

    initial begin
        {tsN, rnw, ovl, configInN, romDelay, addr, dataIn} = {4'b1100, 2'd0, 31'd0, 4'd0};
        rst = 1'b1;
        repeat (16) @(negedge clk40);
        rst = 1'b0;
        // Bridge identity at every offset
        for (int i = 0; i < 64; i++) busCycle(acAddr(7'(i)), 1'b1, 4'h0, 1'b1);
        // Bridge at $20, ATA at $30
        busCycle(acAddr(`AC_BASE_LO), 1'b0, 4'h0, 1'b1);
        busCycle(acAddr(`AC_BASE_HI), 1'b0, 4'h2, 1'b1);
        busCycle(acAddr(`AC_BASE_LO), 1'b0, 4'h0, 1'b1);
        busCycle(acAddr(`AC_BASE_HI), 1'b0, 4'h3, 1'b1);
        busCycle(acAddr(7'd0), 1'b1, 4'h0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            r = randomBits(17);
            busCycle({16'h0020, r[15:0]}, r[16], 4'h0, 1'b1);
            busCycle({16'h0030, r[15:0]}, r[16], 4'h0, 1'b1);
        end
        // Random ROM, flash and RTC cycles
        for (int i = 0; i < 20; i++) begin
            r = randomBits(25);
            romDelay = r[24:23];
            busCycle({8'h00, `ROM_PAGE | {5'd0, r[2:0]}, r[18:3]}, r[19], 4'h0, 1'b1);
            busCycle({8'h00, `FLASH_PAGE | {5'd0, r[22:20]}, r[18:3]}, r[19], 4'h0, 1'b1);
            busCycle({8'h00, `RTC_PAGE, r[18:3]}, r[19], 4'h0, 1'b1);
        end
        ovl = 1'b1;
        repeat (2) busCycle(32'h0000_1000, 1'b1, 4'h0, 1'b1);
        ovl = 1'b0;
        repeat (2) busCycle(32'h0000_1000, 1'b1, 4'h0, 1'b0);
        repeat (2) busCycle(32'h0040_0000, 1'b1, 4'h0, 1'b0);
        // Second pass, ATA board shut up
        applyReset();
        // Board window silent before its base is written
        repeat (2) busCycle(32'h0020_0100, 1'b1, 4'h0, 1'b0);
        busCycle(acAddr(`AC_BASE_LO), 1'b0, 4'h0, 1'b1);
        busCycle(acAddr(`AC_BASE_HI), 1'b0, 4'h2, 1'b1);
        busCycle(acAddr(`AC_SHUTUP), 1'b0, 4'h0, 1'b1);
        repeat (2) busCycle(32'h0030_0100, 1'b1, 4'h0, 1'b0);
        repeat (2) busCycle(32'h0020_0100, 1'b1, 4'h0, 1'b1);
        @(negedge clk40);
        $display("Checker errors: %0d, bench errors: %0d", checkErrors, benchErrors);
        if (checkErrors + benchErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* bench/glue_asserts.sv */
`timescale 1ns/10ps

module glue_asserts (
    input logic              clk40,
    input logic              rst,
    input logic              tsN,
    input logic              cycleOpen,
    input logic              ackPulse,
    input glue_pkg::busSpace space,
    input logic              tackN
);

    import glue_pkg::*;

    // Acknowledge is a single low cycle
    tackOnce: assert property (@(posedge clk40) disable iff (rst) !tackN |=> tackN)
        else $error("tackN held low for more than one cycle");

    // Master starts only once the previous cycle has closed
    noStartWhileOpen: assert property (@(posedge clk40) disable iff (rst)
        !tsN |-> !cycleOpen)
        else $error("bus start while a cycle was still open");

    // Acknowledge only ever ends a cycle to a decoded space
    ackInCycle: assert property (@(posedge clk40) disable iff (rst)
        ackPulse |-> space != spaceNone)
        else $error("ackPulse outside an open cycle");

endmodule

bind glueTop glue_asserts uAsserts (.clk40(clk40), .rst(rst), .tsN(tsN), .cycleOpen(cycleOpen),
    .ackPulse(ackPulse), .space(space), .tackN(tackN));

/* list.f */
+incdir+logic
logic/glue_pkg.sv
logic/addrDecode.sv
logic/autoConfig.sv
logic/cycleControl.sv
logic/deviceStrobes.sv
logic/glueTop.sv
bench/glue_asserts.sv
bench/glueChecker.sv
bench/glueTb.sv

/* logic/addrDecode.sv */
`timescale 1ns/10ps

`include "glue_consts.svh"

module addrDecode (
    input  logic              clk40,
    input  logic              rst,
    input  logic              tsN,
    input  logic              ovl,
    input  logic [31:16]      addr,
    input  logic [7:0]        bridgeBase,
    input  logic [7:0]        ataBase,
    input  logic              configured,
    input  logic              cycleOpen,
    output glue_pkg::busSpace space,
    output logic              cycleStart
);

    import glue_pkg::*;

    localparam logic [7:0] romPage   = `ROM_PAGE;
    localparam logic [7:0] flashPage = `FLASH_PAGE;
    localparam logic [7:0] rtcPage   = `RTC_PAGE;
    localparam logic [7:0] acPage    = `AC_PAGE;

    logic       lowWindow;
    logic [7:0] page;
    busSpace    nextSpace;

    // Everything here sits in the 24-bit Zorro II area
    assign lowWindow = (addr[31:24] == 8'h00);
    assign page      = addr[23:16];

    ///////////////////////////////
    // Space decode
    ///////////////////////////////

    always_comb begin
        nextSpace = spaceNone;
        if (lowWindow) begin
            // ROM at top of map, mirrored to page 0 during overlay
            if (page[7:3] == romPage[7:3] || (ovl && page == 8'h00)) begin
                nextSpace = spaceRom;
            end else if (page[7:3] == flashPage[7:3]) begin
                nextSpace = spaceFlash;
            end else if (page == rtcPage) begin
                nextSpace = spaceRtc;
            end else if (page == acPage && !configured) begin
                // Window closes once chain is done
                nextSpace = spaceAutoconfig;
            end else if (bridgeBase != 8'h00 && page == bridgeBase) begin
                // Zero base = board not mapped yet
                nextSpace = spaceBridge;
            end else if (ataBase != 8'h00 && page == ataBase) begin
                nextSpace = spaceAta;
            end
        end
    end

    ///////////////////////////////
    // Cycle start
    ///////////////////////////////

    // Space holds for the whole cycle
    always_ff @(posedge clk40) begin
        if (rst) begin
            space      <= spaceNone;
            cycleStart <= 1'b0;
        end else begin
            cycleStart <= 1'b0;
            // Start strobe during an open cycle is dropped
            if (!tsN && !cycleOpen) begin
                space      <= nextSpace;
                cycleStart <= 1'b1;
            end
        end
    end

endmodule

/* logic/autoConfig.sv */
`timescale 1ns/10ps

`include "glue_consts.svh"

module autoConfig (
    input  logic              clk40,
    input  logic              rst,
    input  glue_pkg::busSpace space,
    input  logic              rnw,
    input  logic              ackPulse,
    input  logic [7:1]        addr,
    input  logic [3:0]        dataIn,
    input  logic              configInN,
    output logic [3:0]        acData,
    output logic [7:0]        bridgeBase,
    output logic [7:0]        ataBase,
    output logic              configured,
    output logic              configEnN
);

    import glue_pkg::*;

    localparam logic [63:0] bridgeId = `BRIDGE_ID;
    localparam logic [63:0] ataId    = `ATA_ID;

    acState     state;
    acState     nextBoard;
    logic [3:0] loNibble;
    logic [3:0] idNibble;
    logic       acWrite;

    ///////////////////////////////
    // Read side
    ///////////////////////////////

    // Identity of the board now in the window
    always_comb begin
        idNibble = 4'h0;
        // Table covers offsets $00 to $1E, the rest reads as zero
        if (addr[7:5] == 3'b000) begin
            case (state)
                acBridge: idNibble = bridgeId[{addr[4:1], 2'b00} +: 4];
                acAta:    idNibble = ataId[{addr[4:1], 2'b00} +: 4];
                default:  idNibble = 4'h0;
            endcase
        end
    end

    // Offsets $00 and $02 are true, all others inverted
    assign acData = (addr[7:2] == 6'd0) ? idNibble : ~idNibble;

    ///////////////////////////////
    // Write side
    ///////////////////////////////

    // Commit on the acknowledge edge only
    assign acWrite = ackPulse && !rnw && (space == spaceAutoconfig) &&
                     (state != acDone) && !configInN;

    assign nextBoard = (state == acBridge) ? acAta : acDone;

    always_ff @(posedge clk40) begin
        if (rst) begin
            state      <= acBridge;
            loNibble   <= 4'h0;
            bridgeBase <= 8'h00;
            ataBase    <= 8'h00;
        end else if (acWrite) begin
            case (addr)
                // Low nibble waits for the high write
                `AC_BASE_LO: loNibble <= dataIn;
                `AC_BASE_HI: begin
                    // Both nibbles land together so window opens once
                    if (state == acBridge) begin
                        bridgeBase <= {dataIn, loNibble};
                    end else begin
                        ataBase <= {dataIn, loNibble};
                    end
                    state <= nextBoard;
                end
                // Board stays unmapped, base left at zero
                `AC_SHUTUP: state <= nextBoard;
                default: ;
            endcase
        end
    end

    // Chain not reached us yet, or both boards handled
    assign configured = configInN || (state == acDone);
    // Pass chain on to next slot
    assign configEnN  = !(state == acDone && !configInN);

endmodule

/* logic/cycleControl.sv */
`timescale 1ns/10ps

`include "glue_consts.svh"

module cycleControl (
    input  logic              clk40,
    input  logic              rst,
    input  logic              cycleStart,
    input  glue_pkg::busSpace space,
    input  logic [1:0]        romDelay,
    output logic              cycleOpen,
    output logic              ackPulse,
    output logic              tackN
);

    import glue_pkg::*;

    ///////////////////////////////
    // Wait-state table
    ///////////////////////////////

    function automatic logic [3:0] waitStates(input busSpace s, input logic [1:0] delay);
        logic [3:0] w;
        case (s)
            // Slow ROM parts get extra states from the pins
            spaceRom:        w = `ROM_WAIT + {2'b00, delay};
            spaceFlash:      w = `FLASH_WAIT;
            spaceRtc:        w = `RTC_WAIT;
            spaceAutoconfig: w = `AC_WAIT;
            spaceBridge:     w = `BOARD_WAIT;
            spaceAta:        w = `BOARD_WAIT;
            default:         w = 4'd0;
        endcase
        return w;
    endfunction

    logic       startValid;
    logic [3:0] loadWait;
    logic       busy;
    logic [3:0] count;

    // Unmapped cycles never open
    assign startValid = cycleStart && (space != spaceNone);
    assign loadWait   = waitStates(space, romDelay);

    // Zero wait acks straight off the start pulse
    assign ackPulse  = startValid ? (loadWait == 4'd0) : (busy && count == 4'd0);
    assign cycleOpen = startValid || busy;

    ///////////////////////////////
    // Wait counter
    ///////////////////////////////

    always_ff @(posedge clk40) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= 4'd0;
        end else if (startValid) begin
            busy  <= (loadWait != 4'd0);
            // Start cycle already used up one state
            count <= loadWait - 4'd1;
        end else if (ackPulse) begin
            busy <= 1'b0;
        end else if (busy) begin
            count <= count - 4'd1;
        end
    end

    // Single low cycle, one edge after ackPulse
    always_ff @(posedge clk40) begin
        if (rst) begin
            tackN <= 1'b1;
        end else begin
            tackN <= !ackPulse;
        end
    end

endmodule

/* logic/deviceStrobes.sv */
`timescale 1ns/10ps

module deviceStrobes (
    input  logic              clk40,
    input  logic              rst,
    input  glue_pkg::busSpace space,
    input  logic              cycleStart,
    input  logic              ackPulse,
    input  logic              rnw,
    output logic              romEnN,
    output logic              flashEnN,
    output logic              flashReadN,
    output logic              flashWriteN,
    output logic              rtcEnN,
    output logic              bridgeEnN,
    output logic              ataEnN,
    output logic              dataOe
);

    import glue_pkg::*;

    logic held;
    logic ackSeen;
    logic active;

    // Enable span runs from the start pulse through the tackN cycle
    always_ff @(posedge clk40) begin
        if (rst) begin
            held    <= 1'b0;
            ackSeen <= 1'b0;
        end else begin
            // Mirrors tackN low
            ackSeen <= ackPulse;
            if (cycleStart && space != spaceNone) begin
                held <= 1'b1;
            end else if (ackSeen) begin
                held <= 1'b0;
            end
        end
    end

    assign active = cycleStart || held;

    ///////////////////////////////
    // Enables, one per space
    ///////////////////////////////

    assign romEnN    = !(active && space == spaceRom);
    assign flashEnN  = !(active && space == spaceFlash);
    assign rtcEnN    = !(active && space == spaceRtc);
    assign bridgeEnN = !(active && space == spaceBridge);
    assign ataEnN    = !(active && space == spaceAta);

    // Flash strobes track direction over the span
    assign flashReadN  = !(active && space == spaceFlash && rnw);
    assign flashWriteN = !(active && space == spaceFlash && !rnw);

    // Drive nibble back only for config reads
    assign dataOe = active && space == spaceAutoconfig && rnw;

endmodule

/* logic/glueTop.sv */
`timescale 1ns/10ps

module glueTop (
    input  logic        clk40,
    input  logic        rst,
    input  logic        tsN,
    input  logic        rnw,
    input  logic        ovl,
    input  logic [1:0]  romDelay,
    input  logic        configInN,
    input  logic [31:1] addr,
    input  logic [3:0]  dataIn,
    output logic        tackN,
    output logic [3:0]  dataOut,
    output logic        dataOe,
    output logic        configEnN,
    output logic        romEnN,
    output logic        flashEnN,
    output logic        flashReadN,
    output logic        flashWriteN,
    output logic        rtcEnN,
    output logic        bridgeEnN,
    output logic        ataEnN
);

    import glue_pkg::*;

    busSpace    space;
    logic       cycleStart;
    logic       cycleOpen;
    logic       ackPulse;
    logic       configured;
    logic [7:0] bridgeBase;
    logic [7:0] ataBase;
    logic [3:0] acData;

    ///////////////////////////////
    // Decode and acknowledge
    ///////////////////////////////

    addrDecode uDecode (.clk40, .rst, .tsN, .ovl, .addr(addr[31:16]), .bridgeBase,
        .ataBase, .configured, .cycleOpen, .space, .cycleStart);

    cycleControl uControl (.clk40, .rst, .cycleStart, .space, .romDelay, .cycleOpen,
        .ackPulse, .tackN);

    // Config registers see only the low word offset
    autoConfig uAutoConfig (.clk40, .rst, .space, .rnw, .ackPulse, .addr(addr[7:1]),
        .dataIn, .configInN, .acData, .bridgeBase, .ataBase, .configured, .configEnN);

    deviceStrobes uStrobes (.clk40, .rst, .space, .cycleStart, .ackPulse, .rnw, .romEnN,
        .flashEnN, .flashReadN, .flashWriteN, .rtcEnN, .bridgeEnN, .ataEnN, .dataOe);

    assign dataOut = acData;

endmodule

/* logic/glue_consts.svh */
`ifndef GLUE_CONSTS_SVH
`define GLUE_CONSTS_SVH

///////////////////////////////
// Wait states per space
///////////////////////////////

// ROM adds the two-bit delay from the board pins
`define ROM_WAIT    4'd3
`define FLASH_WAIT  4'd4
`define RTC_WAIT    4'd6
`define AC_WAIT     4'd1
`define BOARD_WAIT  4'd2

///////////////////////////////
// AutoConfig registers
///////////////////////////////

// Word offsets on addr[7:1], byte offsets $48, $4A and $4C
`define AC_BASE_HI  7'h24
`define AC_BASE_LO  7'h25
`define AC_SHUTUP   7'h26

// Identity tables, entry 0 in bits 3:0, true (not inverted) values
// Type $C1, product, flags, reserved, manufacturer, serial
`define BRIDGE_ID   64'h1000_C4A1_0000_041C
`define ATA_ID      64'h2000_C4A1_0000_141C

///////////////////////////////
// Fixed pages, addr[23:16]
///////////////////////////////

// ROM and flash span eight pages each
`define ROM_PAGE    8'hF8
`define FLASH_PAGE  8'hF0
`define RTC_PAGE    8'hDC
`define AC_PAGE     8'hE8

`endif

/* logic/glue_pkg.sv */
package glue_pkg;

    ///////////////////////////////
    // Bus spaces
    ///////////////////////////////

    // Space of the open cycle, as latched by the decoder
    typedef enum logic [2:0] {
        // No device here, another board or the bus timeout ends it
        spaceNone       = 3'd0,
        // Boot ROM, also page 0 while overlay is set
        spaceRom        = 3'd1,
        spaceFlash      = 3'd2,
        // Real-time clock
        spaceRtc        = 3'd3,
        // Zorro II config window
        spaceAutoconfig = 3'd4,
        // Autoconfigured 64 KB boards
        spaceBridge     = 3'd5,
        spaceAta        = 3'd6
    } busSpace;

    ///////////////////////////////
    // AutoConfig progress
    ///////////////////////////////

    // One board in the window at a time, bridge first
    typedef enum logic [1:0] {
        acBridge = 2'd0,
        acAta    = 2'd1,
        // Both boards handled, chain passed on
        acDone   = 2'd2
    } acState;

endpackage
